//--- hw/zxdos_pkg.sv
// ==========================================================================
// Shared types and constants of the ZX-Dos board-support base.
// Referenced by scoped name from the RTL and the testbench.
// ==========================================================================
`default_nettype none

package zxdos_pkg;

    // Audio
    typedef logic signed [15:0] sample_t;   // Signed PCM sample from game logic

    // Native game colour, 4 bits per channel
    typedef logic [3:0] rgb4_t;

    // Scan doubler colour, 6 bits per channel
    typedef logic [5:0] rgb6_t;

    // Board resistor DAC, 5 bits per channel
    typedef logic [4:0] rgb5_t;

    // ROM download bus
    typedef logic [21:0] rom_addr_t;        // Byte address into game ROM
    typedef logic [7:0]  rom_byte_t;        // One ROM data byte

    // Core status word, scanlines live in bits 5..3
    typedef logic [31:0] status_t;

    // SPI timing
    // clk_sys cycles per SPI clock half period
    localparam int SPI_HALF  = 2;
    localparam int SPI_CNT_W = (SPI_HALF > 1) ? $clog2(SPI_HALF) : 1;  // Half counter width

    // Bytes fetched in one ROM load
    localparam int ROM_BYTES = 64;

    // Sigma-delta accumulator, sample width plus carry
    localparam int SDM_ACC_W = 17;

    // Loader FSM states
    typedef enum logic [1:0] {
        ST_IDLE,    // Waiting for PLL lock, chip select high
        ST_SHIFT,   // Clocking one byte in from storage
        ST_WRITE,   // One-cycle write strobe
        ST_DONE     // Load finished, parked until reset
    } loader_state_t;

endpackage

`default_nettype wire

//--- hw/sigma_delta_dac.sv
// ==========================================================================
// First-order sigma-delta DAC for one audio channel.
// Signed sample in, one-bit stream out; board RC filter does the rest.
// ==========================================================================
`timescale 1ns/10ps
`default_nettype none

module sigma_delta_dac (
    input  wire                     clk_sys,
    input  wire                     rst_n,
    input  wire zxdos_pkg::sample_t sample,     // Signed PCM input
    output logic                    pwm         // Bit stream to pin
);

    // Accumulator, top bit is the carry out
    logic [zxdos_pkg::SDM_ACC_W-1:0] acc;

    // Sample as offset binary, 0x8000 is silence
    logic [zxdos_pkg::SDM_ACC_W-2:0] level;

    // Flip sign bit for offset binary
    assign level = {~sample[15], sample[14:0]};

    // Carry of previous sum is dropped before the next add
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else begin
            acc <= {1'b0, acc[zxdos_pkg::SDM_ACC_W-2:0]} + {1'b0, level};
        end
    end

    // Output is the registered carry, one cycle after the sample
    assign pwm = acc[zxdos_pkg::SDM_ACC_W-1];

    // Output must be clean once out of reset
    a_pwm_known : assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        !$isunknown(pwm)
    ) else $error("sigma_delta_dac: pwm unknown");

endmodule

`default_nettype wire

//--- hw/spi_rom_loader.sv
// ==========================================================================
// ROM loader. Reads ROM_BYTES bytes from SPI storage in mode 0 and
// issues one addressed write strobe per byte on the ioctl bus.
// Starts once the PLL is locked, then parks until the next reset.
// ==========================================================================
`timescale 1ns/10ps
`default_nettype none

module spi_rom_loader (
    input  wire                        clk_sys,
    input  wire                        rst_n,
    input  wire                        pll_locked,
    input  wire                        sd_miso,      // Storage data out
    output logic                       sd_cs_n,
    output logic                       sd_clk,
    output logic                       sd_mosi,
    output zxdos_pkg::rom_addr_t       ioctl_addr,
    output zxdos_pkg::rom_byte_t       ioctl_data,
    output logic                       ioctl_wr,     // One-cycle strobe
    output logic                       downloading   // High during the load
);

    zxdos_pkg::loader_state_t          state;
    logic [zxdos_pkg::SPI_CNT_W-1:0]   half_cnt;     // Cycles within half period
    logic [2:0]                        bit_cnt;      // Bits done in this byte
    zxdos_pkg::rom_byte_t              shift_reg;    // MSB first

    logic half_end;     // Last cycle of a half period
    logic rise_tick;    // sd_clk goes high on this edge
    logic fall_tick;    // sd_clk goes low on this edge
    logic byte_end;     // Falling edge after the eighth bit

    assign half_end  = (state == zxdos_pkg::ST_SHIFT) &&
                       (int'(half_cnt) == zxdos_pkg::SPI_HALF - 1);
    assign rise_tick = half_end && !sd_clk;
    assign fall_tick = half_end && sd_clk;
    assign byte_end  = fall_tick && (bit_cnt == 3'd7);

    // No commands go out, storage is a plain byte stream
    assign sd_mosi = 1'b0;

    // Control FSM
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            state       <= zxdos_pkg::ST_IDLE;
            half_cnt    <= '0;
            bit_cnt     <= '0;
            sd_cs_n     <= 1'b1;
            sd_clk      <= 1'b0;
            ioctl_addr  <= '0;
            ioctl_wr    <= 1'b0;
            downloading <= 1'b0;
        end else begin
            ioctl_wr <= 1'b0;   // Strobe by default off
            case (state)
                zxdos_pkg::ST_IDLE: begin
                    // Hold off until clocks are stable
                    if (pll_locked) begin
                        state       <= zxdos_pkg::ST_SHIFT;
                        sd_cs_n     <= 1'b0;
                        downloading <= 1'b1;
                        half_cnt    <= '0;
                        bit_cnt     <= '0;
                    end
                end
                zxdos_pkg::ST_SHIFT: begin
                    if (half_end) begin
                        half_cnt <= '0;
                        sd_clk   <= ~sd_clk;
                        if (fall_tick) begin
                            bit_cnt <= bit_cnt + 3'd1;  // Wraps to 0 after byte
                        end
                        if (byte_end) begin
                            state    <= zxdos_pkg::ST_WRITE;
                            ioctl_wr <= 1'b1;
                        end
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                zxdos_pkg::ST_WRITE: begin
                    // Strobe is high in this cycle, clock stays low
                    if (ioctl_addr == zxdos_pkg::rom_addr_t'(zxdos_pkg::ROM_BYTES - 1)) begin
                        state       <= zxdos_pkg::ST_DONE;
                        sd_cs_n     <= 1'b1;
                        downloading <= 1'b0;
                    end else begin
                        state      <= zxdos_pkg::ST_SHIFT;
                        ioctl_addr <= ioctl_addr + 1'b1;
                        half_cnt   <= '0;
                    end
                end
                default: begin
                    // ST_DONE, wait for reset
                    sd_cs_n     <= 1'b1;
                    sd_clk      <= 1'b0;
                    downloading <= 1'b0;
                end
            endcase
        end
    end

    // Data path, sample on the rising SPI edge
    always_ff @(posedge clk_sys) begin
        if (rise_tick) begin
            shift_reg <= {shift_reg[6:0], sd_miso};
        end
        if (byte_end) begin
            ioctl_data <= shift_reg;    // Full byte, last bit already in
        end
    end

    a_wr_in_load : assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        ioctl_wr |-> downloading
    ) else $error("spi_rom_loader: write strobe outside download");

    // Mode 0 clock must idle low whenever the device is deselected
    a_clk_idle : assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        sd_cs_n |-> !sd_clk
    ) else $error("spi_rom_loader: sd_clk active with chip select high");

endmodule

`default_nettype wire

//--- hw/video_out_sel.sv
// ==========================================================================
// Final video mux. Picks 15 kHz RGB with composite sync or the
// scan-doubled VGA signal, and reports the scanline level in status.
// ==========================================================================
`timescale 1ns/10ps
`default_nettype none

module video_out_sel (
    input  wire                    clk_sys,
    input  wire                    rst_n,
    input  wire zxdos_pkg::rgb4_t  game_r,      // Native colour
    input  wire zxdos_pkg::rgb4_t  game_g,
    input  wire zxdos_pkg::rgb4_t  game_b,
    input  wire                    hs,          // Native syncs, active high
    input  wire                    vs,
    input  wire zxdos_pkg::rgb6_t  scan2x_r,    // From scan doubler
    input  wire zxdos_pkg::rgb6_t  scan2x_g,
    input  wire zxdos_pkg::rgb6_t  scan2x_b,
    input  wire                    scan2x_hs,
    input  wire                    scan2x_vs,
    input  wire [3:0]              vgactrl_en,  // Keyboard video control
    input  wire [1:0]              videoconf,   // BIOS video setting
    output logic                   scan2x_enb,  // 1 selects native video
    output zxdos_pkg::rgb5_t       video_r,
    output zxdos_pkg::rgb5_t       video_g,
    output zxdos_pkg::rgb5_t       video_b,
    output logic                   video_hs,
    output logic                   video_vs,
    output zxdos_pkg::status_t     status
);

    logic       native;         // Mode of this cycle
    logic       csync;          // Composite sync for SCART
    logic [2:0] scanlines;      // Scanline level, wraps mod 8

    // BIOS bit sets the default, keyboard bit toggles it
    assign native = ~videoconf[0] ^ vgactrl_en[0];

    // SCART cable wants csync on HS pin
    assign csync = ~((~hs) ^ (~vs));

    // BIOS bit offsets the level so it can start at 0 or 1
    assign scanlines = vgactrl_en[3:1] + {2'b00, videoconf[1]};

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            scan2x_enb <= 1'b0;
            video_r    <= '0;
            video_g    <= '0;
            video_b    <= '0;
            video_hs   <= 1'b0;
            video_vs   <= 1'b0;
            status     <= '0;
        end else begin
            scan2x_enb <= native;
            if (native) begin
                // Repeat the top bit to fill the fifth bit
                video_r  <= {game_r, game_r[3]};
                video_g  <= {game_g, game_g[3]};
                video_b  <= {game_b, game_b[3]};
                video_hs <= csync;
                video_vs <= 1'b1;   // Held high to switch the TV into RGB
            end else begin
                // Drop the doubler LSB
                video_r  <= scan2x_r[5:1];
                video_g  <= scan2x_g[5:1];
                video_b  <= scan2x_b[5:1];
                video_hs <= scan2x_hs;
                video_vs <= scan2x_vs;
            end
            status <= {26'd0, scanlines, 3'd0};
        end
    end

    // Native mode must reach the VS pin one cycle later
    a_native_vs : assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        native |=> video_vs
    ) else $error("video_out_sel: video_vs low in native mode");

endmodule

`default_nettype wire

//--- hw/zxdos_base.sv
// ==========================================================================
// ZX-Dos board-support base. Sits between the game logic and the pins:
// audio DACs, SPI ROM download and final video selection.
// ==========================================================================
`timescale 1ns/10ps
`default_nettype none

module zxdos_base (
    input  wire                        clk_sys,
    input  wire                        rst_n,
    input  wire                        pll_locked,
    // Sound
    input  wire zxdos_pkg::sample_t    snd_left,
    input  wire zxdos_pkg::sample_t    snd_right,
    output wire                        snd_pwm_l,
    output wire                        snd_pwm_r,
    // SPI storage
    output wire                        sd_cs_n,
    output wire                        sd_clk,
    output wire                        sd_mosi,
    input  wire                        sd_miso,
    // ROM download to game memory
    output wire zxdos_pkg::rom_addr_t  ioctl_addr,
    output wire zxdos_pkg::rom_byte_t  ioctl_data,
    output wire                        ioctl_wr,
    output wire                        downloading,
    // Native video
    input  wire zxdos_pkg::rgb4_t      game_r,
    input  wire zxdos_pkg::rgb4_t      game_g,
    input  wire zxdos_pkg::rgb4_t      game_b,
    input  wire                        hs,
    input  wire                        vs,
    // Scan doubler video
    input  wire zxdos_pkg::rgb6_t      scan2x_r,
    input  wire zxdos_pkg::rgb6_t      scan2x_g,
    input  wire zxdos_pkg::rgb6_t      scan2x_b,
    input  wire                        scan2x_hs,
    input  wire                        scan2x_vs,
    input  wire [3:0]                  vgactrl_en,
    input  wire [1:0]                  videoconf,
    output wire                        scan2x_enb,   // Scan doubler disable
    // Board video
    output wire zxdos_pkg::rgb5_t      video_r,
    output wire zxdos_pkg::rgb5_t      video_g,
    output wire zxdos_pkg::rgb5_t      video_b,
    output wire                        video_hs,
    output wire                        video_vs,
    output wire zxdos_pkg::status_t    status
);

    // Left audio
    sigma_delta_dac u_dac_l (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .sample  (snd_left),
        .pwm     (snd_pwm_l)
    );

    // Right audio, same modulator
    sigma_delta_dac u_dac_r (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .sample  (snd_right),
        .pwm     (snd_pwm_r)
    );

    spi_rom_loader u_loader (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .pll_locked  (pll_locked),
        .sd_miso     (sd_miso),
        .sd_cs_n     (sd_cs_n),
        .sd_clk      (sd_clk),
        .sd_mosi     (sd_mosi),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .downloading (downloading)
    );

    video_out_sel u_video (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .game_r     (game_r),
        .game_g     (game_g),
        .game_b     (game_b),
        .hs         (hs),
        .vs         (vs),
        .scan2x_r   (scan2x_r),
        .scan2x_g   (scan2x_g),
        .scan2x_b   (scan2x_b),
        .scan2x_hs  (scan2x_hs),
        .scan2x_vs  (scan2x_vs),
        .vgactrl_en (vgactrl_en),
        .videoconf  (videoconf),
        .scan2x_enb (scan2x_enb),
        .video_r    (video_r),
        .video_g    (video_g),
        .video_b    (video_b),
        .video_hs   (video_hs),
        .video_vs   (video_vs),
        .status     (status)
    );

endmodule

`default_nettype wire

//--- sim/tb_zxdos_base.sv
// ==========================================================================
// Self-checking testbench for the ZX-Dos board-support base.
// Models the SPI storage device, checks reset, ROM load, both DAC streams,
// video selection and the scanline status against reference functions.
// ==========================================================================
`timescale 1ns/10ps
`default_nettype none

module tb_zxdos_base;

    // Run lengths in clk_sys cycles
    localparam int RESET_CYCLES = 10;
    localparam int HOLD_CYCLES  = 300;  // One DAC sample hold
    localparam int DAC_SEGS     = 8;
    localparam int VIDEO_RUN    = 100;
    localparam int COMBO_RUN    = 20;   // Per mode bit combination
    localparam int STATUS_RUN   = 3;
    localparam int ROM_CYCLES   = zxdos_pkg::ROM_BYTES * (8 * 2 * zxdos_pkg::SPI_HALF + 4);
    localparam int DAC_CYCLES   = DAC_SEGS * HOLD_CYCLES;
    localparam int VIDEO_CYCLES = 2 * VIDEO_RUN + 4 * COMBO_RUN + 32 * STATUS_RUN;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + ROM_CYCLES + DAC_CYCLES + VIDEO_CYCLES + 1000;

    // DUT inputs
    logic                 clk_sys;
    logic                 rst_n;
    logic                 pll_locked;
    zxdos_pkg::sample_t   snd_left;
    zxdos_pkg::sample_t   snd_right;
    logic                 sd_miso;
    zxdos_pkg::rgb4_t     game_r, game_g, game_b;
    logic                 hs, vs;
    zxdos_pkg::rgb6_t     scan2x_r, scan2x_g, scan2x_b;
    logic                 scan2x_hs, scan2x_vs;
    logic [3:0]           vgactrl_en;
    logic [1:0]           videoconf;

    // DUT outputs
    logic                 snd_pwm_l, snd_pwm_r;
    logic                 sd_cs_n, sd_clk, sd_mosi;
    zxdos_pkg::rom_addr_t ioctl_addr;
    zxdos_pkg::rom_byte_t ioctl_data;
    logic                 ioctl_wr, downloading;
    logic                 scan2x_enb;
    zxdos_pkg::rgb5_t     video_r, video_g, video_b;
    logic                 video_hs, video_vs;
    zxdos_pkg::status_t   status;

    // Bookkeeping
    int          err_count, check_count, tests_done, test_err_start;
    int          wr_count;                  // Strobes seen so far
    logic        dl_prev;
    logic        dac_check_on, video_check_on;
    logic [31:0] lcg_state;
    logic [3:0]  states_seen;               // Loader FSM coverage

    zxdos_pkg::rom_byte_t rom_image [0:zxdos_pkg::ROM_BYTES-1];   // Storage contents

    // Reference state
    logic [16:0]        ref_acc_l, ref_acc_r;
    logic               exp_enb, exp_hs, exp_vs;
    zxdos_pkg::rgb5_t   exp_r, exp_g, exp_b;
    zxdos_pkg::status_t exp_status;

    // Storage model state
    int   miso_idx;                         // Bit position in the image
    logic clk_prev;

    zxdos_base u_dut (
        .clk_sys(clk_sys), .rst_n(rst_n), .pll_locked(pll_locked),
        .snd_left(snd_left), .snd_right(snd_right),
        .snd_pwm_l(snd_pwm_l), .snd_pwm_r(snd_pwm_r),
        .sd_cs_n(sd_cs_n), .sd_clk(sd_clk), .sd_mosi(sd_mosi), .sd_miso(sd_miso),
        .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
        .ioctl_wr(ioctl_wr), .downloading(downloading),
        .game_r(game_r), .game_g(game_g), .game_b(game_b), .hs(hs), .vs(vs),
        .scan2x_r(scan2x_r), .scan2x_g(scan2x_g), .scan2x_b(scan2x_b),
        .scan2x_hs(scan2x_hs), .scan2x_vs(scan2x_vs),
        .vgactrl_en(vgactrl_en), .videoconf(videoconf), .scan2x_enb(scan2x_enb),
        .video_r(video_r), .video_g(video_g), .video_b(video_b),
        .video_hs(video_hs), .video_vs(video_vs), .status(status)
    );

    always #10 clk_sys = ~clk_sys;          // 50 MHz

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // One modulator step with offset binary as sample plus half scale
    function automatic logic [16:0] sdm_step(input logic [16:0] acc,
                                             input zxdos_pkg::sample_t s);
        logic [15:0] offset;
        offset = 16'(s) + 16'h8000;
        return {1'b0, acc[15:0]} + {1'b0, offset};
    endfunction

    // Native when both mode bits agree
    function automatic logic mode_ref(input logic vc0, input logic en0);
        return vc0 == en0;
    endfunction

    function automatic zxdos_pkg::rgb5_t colour_ref(input logic native,
                                                    input zxdos_pkg::rgb4_t game,
                                                    input zxdos_pkg::rgb6_t dbl);
        if (native) begin
            return {game, game[3]};         // Top bit repeated as LSB
        end else begin
            return dbl[5:1];
        end
    endfunction

    function automatic zxdos_pkg::status_t status_ref(input logic [3:0] en, input logic vc1);
        int level;
        level = (int'(en) / 2 + int'(vc1)) % 8;
        return zxdos_pkg::status_t'(level * 8);     // Field starts at bit 3
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            $display("Fail %s at %0t: got 0x%0h expected 0x%0h", name, $time, got, exp);
            err_count++;
        end
    endtask

    task automatic check_addr(input string name, input zxdos_pkg::rom_addr_t got,
                              input zxdos_pkg::rom_addr_t exp);
        check_count++;
        if (got !== exp) begin
            $display("Fail %s at %0t: got 0x%0h expected 0x%0h", name, $time, got, exp);
            err_count++;
        end
    endtask

    task automatic check_byte(input string name, input zxdos_pkg::rom_byte_t got,
                              input zxdos_pkg::rom_byte_t exp);
        check_count++;
        if (got !== exp) begin
            $display("Fail %s at %0t: got 0x%0h expected 0x%0h", name, $time, got, exp);
            err_count++;
        end
    endtask

    task automatic check_rgb5(input string name, input zxdos_pkg::rgb5_t got,
                              input zxdos_pkg::rgb5_t exp);
        check_count++;
        if (got !== exp) begin
            $display("Fail %s at %0t: got 0x%0h expected 0x%0h", name, $time, got, exp);
            err_count++;
        end
    endtask

    task automatic check_status(input string name, input zxdos_pkg::status_t got,
                                input zxdos_pkg::status_t exp);
        check_count++;
        if (got !== exp) begin
            $display("Fail %s at %0t: got 0x%0h expected 0x%0h", name, $time, got, exp);
            err_count++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic end_test(input string name);
        $display("test %0d %s: %0d errors", tests_done + 1, name, err_count - test_err_start);
        tests_done++;
        test_err_start = err_count;
    endtask

    // New random colours and syncs driven at the current edge
    task drive_random_video();
        logic [31:0] r;
        lcg_state = lcg_next(lcg_state);
        r = lcg_state;
        game_r    <= r[31:28];
        game_g    <= r[27:24];
        game_b    <= r[23:20];
        hs        <= r[19];
        vs        <= r[18];
        lcg_state = lcg_next(lcg_state);
        r = lcg_state;
        scan2x_r  <= r[31:26];
        scan2x_g  <= r[25:20];
        scan2x_b  <= r[19:14];
        scan2x_hs <= r[13];
        scan2x_vs <= r[12];
    endtask

    // Storage device puts the next bit out after each falling sd_clk
    always @(posedge clk_sys) begin
        if (sd_cs_n) begin
            miso_idx = 0;                   // Stream restarts on select
        end else if (clk_prev && !sd_clk) begin
            miso_idx = miso_idx + 1;
        end
        clk_prev = sd_clk;
        if (miso_idx < zxdos_pkg::ROM_BYTES * 8) begin
            sd_miso <= rom_image[miso_idx / 8][7 - miso_idx % 8];   // MSB first
        end else begin
            sd_miso <= 1'b0;
        end
    end

    // Reference models fed with the values the DUT sees at the edge
    always @(posedge clk_sys) begin
        if (!rst_n) begin
            ref_acc_l  = '0;
            ref_acc_r  = '0;
            exp_enb    = 1'b0;
            exp_r      = '0;
            exp_g      = '0;
            exp_b      = '0;
            exp_hs     = 1'b0;
            exp_vs     = 1'b0;
            exp_status = '0;
        end else begin
            ref_acc_l  = sdm_step(ref_acc_l, snd_left);
            ref_acc_r  = sdm_step(ref_acc_r, snd_right);
            exp_enb    = mode_ref(videoconf[0], vgactrl_en[0]);
            exp_r      = colour_ref(exp_enb, game_r, scan2x_r);
            exp_g      = colour_ref(exp_enb, game_g, scan2x_g);
            exp_b      = colour_ref(exp_enb, game_b, scan2x_b);
            exp_hs     = exp_enb ? (hs == vs) : scan2x_hs;  // Composite sync in native
            exp_vs     = exp_enb ? 1'b1 : scan2x_vs;
            exp_status = status_ref(vgactrl_en, videoconf[1]);
        end
    end

    // Output comparison at mid cycle
    always @(negedge clk_sys) begin
        if (dac_check_on) begin
            check_bit("snd_pwm_l", snd_pwm_l, ref_acc_l[16]);
            check_bit("snd_pwm_r", snd_pwm_r, ref_acc_r[16]);
        end
        if (video_check_on) begin
            check_bit("scan2x_enb", scan2x_enb, exp_enb);
            check_rgb5("video_r", video_r, exp_r);
            check_rgb5("video_g", video_g, exp_g);
            check_rgb5("video_b", video_b, exp_b);
            check_bit("video_hs", video_hs, exp_hs);
            check_bit("video_vs", video_vs, exp_vs);
            check_status("status", status, exp_status);
        end
    end

    // Write strobe monitor and loader state coverage
    always @(negedge clk_sys) begin
        if (rst_n) begin
            states_seen[u_dut.u_loader.state] = 1'b1;
        end
        if (ioctl_wr) begin
            check_bit("downloading", downloading, 1'b1);
            if (wr_count < zxdos_pkg::ROM_BYTES) begin
                check_addr("ioctl_addr", ioctl_addr, zxdos_pkg::rom_addr_t'(wr_count));
                check_byte("ioctl_data", ioctl_data, rom_image[wr_count]);
            end else begin
                report_error("write strobe after the last ROM byte");
            end
            wr_count++;
        end
        if (dl_prev && !downloading && wr_count != zxdos_pkg::ROM_BYTES) begin
            report_error($sformatf("downloading fell after %0d of %0d strobes",
                                   wr_count, zxdos_pkg::ROM_BYTES));
        end
        dl_prev = downloading;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin
        clk_sys = 1'b0;
        rst_n = 1'b0;
        pll_locked = 1'b0;
        snd_left = '0;
        snd_right = '0;
        sd_miso = 1'b0;
        game_r = '0;
        game_g = '0;
        game_b = '0;
        hs = 1'b0;
        vs = 1'b0;
        scan2x_r = '0;
        scan2x_g = '0;
        scan2x_b = '0;
        scan2x_hs = 1'b0;
        scan2x_vs = 1'b0;
        vgactrl_en = 4'h0;
        videoconf = 2'b00;
        err_count = 0;
        check_count = 0;
        tests_done = 0;
        test_err_start = 0;
        wr_count = 0;
        dl_prev = 1'b0;
        dac_check_on = 1'b0;
        video_check_on = 1'b0;
        states_seen = 4'h0;
        miso_idx = 0;
        clk_prev = 1'b0;
        lcg_state = 32'd37;
        for (int i = 0; i < zxdos_pkg::ROM_BYTES; i++) begin
            lcg_state = lcg_next(lcg_state);
            rom_image[i] = lcg_state[23:16];
        end

        // Reset with the PLL still unlocked
        repeat (RESET_CYCLES) @(posedge clk_sys);
        rst_n <= 1'b1;
        @(negedge clk_sys);
        check_bit("sd_cs_n", sd_cs_n, 1'b1);
        check_bit("sd_clk", sd_clk, 1'b0);
        check_bit("sd_mosi", sd_mosi, 1'b0);
        check_bit("ioctl_wr", ioctl_wr, 1'b0);
        check_bit("downloading", downloading, 1'b0);
        check_bit("snd_pwm_l", snd_pwm_l, 1'b0);
        check_bit("snd_pwm_r", snd_pwm_r, 1'b0);
        end_test("reset state");

        // ROM load starts on lock
        @(posedge clk_sys);
        pll_locked <= 1'b1;
        while (!downloading) @(negedge clk_sys);
        while (downloading) @(negedge clk_sys);
        repeat (4) @(negedge clk_sys);   // No late strobes
        if (wr_count != zxdos_pkg::ROM_BYTES) begin
            report_error($sformatf("%0d write strobes seen, %0d expected",
                                   wr_count, zxdos_pkg::ROM_BYTES));
        end
        check_bit("sd_cs_n", sd_cs_n, 1'b1);
        check_bit("sd_clk", sd_clk, 1'b0);
        check_bit("sd_mosi", sd_mosi, 1'b0);
        $display("loader states seen: idle %0b shift %0b write %0b done %0b",
                 states_seen[zxdos_pkg::ST_IDLE], states_seen[zxdos_pkg::ST_SHIFT],
                 states_seen[zxdos_pkg::ST_WRITE], states_seen[zxdos_pkg::ST_DONE]);
        check_bit("loader_states_all", &states_seen, 1'b1);
        end_test("rom load");

        // Sigma-delta streams
        @(posedge clk_sys);
        dac_check_on = 1'b1;
        for (int seg = 0; seg < DAC_SEGS; seg++) begin
            lcg_state = lcg_next(lcg_state);
            snd_left  <= lcg_state[31:16];
            snd_right <= lcg_state[15:0];
            repeat (HOLD_CYCLES) @(posedge clk_sys);
        end
        dac_check_on = 1'b0;
        end_test("sigma-delta streams");

        // Native video with both mode bits low
        @(posedge clk_sys);
        video_check_on = 1'b1;
        videoconf  <= 2'b00;
        vgactrl_en <= 4'h0;
        drive_random_video();
        repeat (VIDEO_RUN - 1) begin
            @(posedge clk_sys);
            drive_random_video();
        end
        repeat (2) @(posedge clk_sys);  // Last outputs checked
        end_test("native video");

        // Scan-doubled video and then every mode bit pair
        @(posedge clk_sys);
        videoconf  <= 2'b01;
        vgactrl_en <= 4'h0;
        drive_random_video();
        repeat (VIDEO_RUN - 1) begin
            @(posedge clk_sys);
            drive_random_video();
        end
        for (int combo = 0; combo < 4; combo++) begin
            @(posedge clk_sys);
            videoconf  <= {1'b0, combo[1]};
            vgactrl_en <= {3'b000, combo[0]};
            drive_random_video();
            repeat (COMBO_RUN - 1) begin
                @(posedge clk_sys);
                drive_random_video();
            end
        end
        repeat (2) @(posedge clk_sys);
        end_test("scan-doubled video");

        // Scanline field over all control values
        for (int v = 0; v < 16; v++) begin
            for (int c = 0; c < 2; c++) begin
                @(posedge clk_sys);
                vgactrl_en <= v[3:0];
                videoconf  <= {c[0], 1'b0};
                drive_random_video();
                repeat (STATUS_RUN - 1) @(posedge clk_sys);
            end
        end
        repeat (2) @(posedge clk_sys);
        video_check_on = 1'b0;
        end_test("status field");

        $display("tests %0d, checks %0d, errors %0d", tests_done, check_count, err_count);
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- zxdos_base.f
hw/zxdos_pkg.sv
hw/sigma_delta_dac.sv
hw/spi_rom_loader.sv
hw/video_out_sel.sv
hw/zxdos_base.sv
sim/tb_zxdos_base.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_zxdos_base
FILELIST  = zxdos_base.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build and run; status follows the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf $(OBJ_DIR)
